// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Width of a machine word, which is also the instruction width
`define DATA_WIDTH 16

// Unified memory size in words
`define MEM_DEPTH 256

// Bits of a word address that actually reach the memory array
`define MEM_ADDR_WIDTH $clog2(`MEM_DEPTH)

// General purpose registers
`define REG_COUNT 4

// Bits needed to name one register
`define REG_INDEX_WIDTH $clog2(`REG_COUNT)

// Widths of the two immediate formats
`define IMM_WIDTH 10
`define OFFSET_WIDTH 12

`endif

// File: hdl/isaPkg.sv
`default_nettype none

`include "cpu_settings.svh"

package isaPkg;

	// Codes not listed here execute as no-operations
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_LI   = 4'h2,
		OP_LD   = 4'h3,
		OP_LDA  = 4'h4,
		OP_ST   = 4'h5,
		OP_STA  = 4'h6,
		OP_BZ   = 4'h7,
		OP_BR   = 4'h8,
		OP_JR   = 4'h9,
		OP_HALT = 4'hf
	} opcode_t;

	// ADD, SUB: rd = rs1 op rs2. LD: rd = mem[rs1]. ST: mem[rs1] = rd. JR: pc = rs1
	typedef struct packed {
		opcode_t opcode;
		logic [1:0] rd;
		logic [1:0] rs1;
		logic [1:0] rs2;
		logic [5:0] spare;
	} rFormat_t;

	// LI: rd = imm. LDA: rd = mem[imm]. STA: mem[imm] = rd
	typedef struct packed {
		opcode_t opcode;
		logic [1:0] rd;
		logic [`IMM_WIDTH-1:0] imm;
	} iFormat_t;

	// BZ and BR add the offset to the PC of the branch itself
	typedef struct packed {
		opcode_t opcode;
		logic [`OFFSET_WIDTH-1:0] offset;
	} bFormat_t;

	// Three overlapping views of the same instruction word
	typedef union packed {
		rFormat_t r;
		iFormat_t i;
		bFormat_t b;
	} instrFields_t;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_IMM} wbSel_t;

	typedef enum logic [1:0] {PC_INC, PC_REL, PC_REG, PC_HOLD} pcSel_t;

	typedef struct packed {
		logic regWrite;
		logic [`REG_INDEX_WIDTH-1:0] regDest;
		logic [`REG_INDEX_WIDTH-1:0] regSrc1;
		logic [`REG_INDEX_WIDTH-1:0] regSrc2;
		logic aluSub;
		logic aluUpdate;
		logic memWrite;
		logic dAddrFromReg;
		wbSel_t wbSel;
		pcSel_t pcSel;
	} control_t;

endpackage

`default_nettype wire

// File: hdl/tracePkg.sv
`default_nettype none

`include "cpu_settings.svh"

package tracePkg;

	// One word written into memory per strobe, only while the core is in reset
	typedef struct packed {
		logic strobe;
		logic [`DATA_WIDTH-1:0] addr;
		logic [`DATA_WIDTH-1:0] data;
	} loadWrite_t;

	// Everything a retiring instruction changes
	typedef struct packed {
		logic strobe;
		logic [`DATA_WIDTH-1:0] pc;
		logic [`DATA_WIDTH-1:0] instruction;
		logic regWrite;
		logic [`REG_INDEX_WIDTH-1:0] regIndex;
		logic [`DATA_WIDTH-1:0] regData;
		logic memWrite;
		logic [`DATA_WIDTH-1:0] memAddr;
		logic [`DATA_WIDTH-1:0] memData;
	} retire_t;

endpackage

`default_nettype wire

// File: hdl/memory.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module memory
	import tracePkg::*;
(
	input wire logic clk,
	input wire logic [`DATA_WIDTH-1:0] iAddr,
	output logic [`DATA_WIDTH-1:0] iData,
	input wire logic [`DATA_WIDTH-1:0] dAddr,
	input wire logic dWrite,
	input wire logic [`DATA_WIDTH-1:0] dDataIn,
	output logic [`DATA_WIDTH-1:0] dDataOut,
	input wire loadWrite_t load
);

	logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

	// Only the low address bits select a word, the rest wrap around
	assign iData = mem[iAddr[`MEM_ADDR_WIDTH-1:0]];
	assign dDataOut = mem[dAddr[`MEM_ADDR_WIDTH-1:0]];

	// Program loading wins over a data store
	always_ff @(posedge clk) begin
		if (load.strobe) begin
			mem[load.addr[`MEM_ADDR_WIDTH-1:0]] <= load.data;
		end
		else if (dWrite) begin
			mem[dAddr[`MEM_ADDR_WIDTH-1:0]] <= dDataIn;
		end
	end

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module registerFile (
	input wire logic clk,
	input wire logic rst,
	input wire logic we,
	input wire logic [`REG_INDEX_WIDTH-1:0] inReg,
	input wire logic [`DATA_WIDTH-1:0] dataIn,
	input wire logic [`REG_INDEX_WIDTH-1:0] outReg1,
	input wire logic [`REG_INDEX_WIDTH-1:0] outReg2,
	output logic [`DATA_WIDTH-1:0] dataOut1,
	output logic [`DATA_WIDTH-1:0] dataOut2
);

	logic [`REG_COUNT-1:0][`DATA_WIDTH-1:0] regs;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			regs <= '0;
		end
		else if (we) begin
			regs[inReg] <= dataIn;
		end
	end

	// Reads see the old value when the same register is written this cycle
	assign dataOut1 = regs[outReg1];
	assign dataOut2 = regs[outReg2];

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module alu (
	input wire logic clk,
	input wire logic rst,
	input wire logic [`DATA_WIDTH-1:0] in1,
	input wire logic [`DATA_WIDTH-1:0] in2,
	input wire logic sub,
	input wire logic update,
	output logic [`DATA_WIDTH-1:0] result,
	output logic zFlag
);

	always_comb begin
		if (sub) begin
			result = in1 - in2;
		end
		else begin
			result = in1 + in2;
		end
	end

	// Flag keeps the zero status of the last ADD or SUB only
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			zFlag <= 1'b0;
		end
		else if (update) begin
			zFlag <= (result == '0);
		end
	end

endmodule

`default_nettype wire

// File: hdl/decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module decoder
	import isaPkg::*;
(
	input wire instrFields_t instruction,
	input wire logic active,
	input wire logic zFlag,
	output control_t ctrl,
	output logic [`DATA_WIDTH-1:0] imm
);

	logic [`DATA_WIDTH-1:0] immShort;
	logic [`DATA_WIDTH-1:0] immLong;

	// Sign extension for the I-type and branch formats
	assign immShort = {{(`DATA_WIDTH-`IMM_WIDTH){instruction.i.imm[`IMM_WIDTH-1]}},
		instruction.i.imm};
	assign immLong = {{(`DATA_WIDTH-`OFFSET_WIDTH){instruction.b.offset[`OFFSET_WIDTH-1]}},
		instruction.b.offset};

	always_comb begin
		ctrl = '0;
		ctrl.regDest = instruction.r.rd;
		ctrl.regSrc1 = instruction.r.rs1;
		ctrl.regSrc2 = instruction.r.rs2;
		ctrl.wbSel = WB_ALU;
		ctrl.pcSel = PC_INC;
		imm = immShort;

		case (instruction.r.opcode)
			OP_ADD: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluUpdate = 1'b1;
			end
			OP_SUB: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluUpdate = 1'b1;
				ctrl.aluSub = 1'b1;
			end
			OP_LI: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = WB_IMM;
			end
			OP_LD: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = WB_MEM;
				ctrl.dAddrFromReg = 1'b1;
			end
			OP_LDA: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = WB_MEM;
			end
			// Store data comes from rd through read port 2
			OP_ST: begin
				ctrl.memWrite = 1'b1;
				ctrl.dAddrFromReg = 1'b1;
				ctrl.regSrc2 = instruction.r.rd;
			end
			OP_STA: begin
				ctrl.memWrite = 1'b1;
				ctrl.regSrc2 = instruction.r.rd;
			end
			OP_BZ: begin
				imm = immLong;
				ctrl.pcSel = zFlag ? PC_REL : PC_INC;
			end
			OP_BR: begin
				imm = immLong;
				ctrl.pcSel = PC_REL;
			end
			OP_JR: begin
				ctrl.pcSel = PC_REG;
			end
			OP_HALT: begin
				ctrl.pcSel = PC_HOLD;
			end
			default: begin
			end
		endcase

		// Idle or halted core changes nothing
		if (!active) begin
			ctrl.regWrite = 1'b0;
			ctrl.memWrite = 1'b0;
			ctrl.aluUpdate = 1'b0;
			ctrl.pcSel = PC_HOLD;
		end
	end

endmodule

`default_nettype wire

// File: hdl/programCounter.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module programCounter
	import isaPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire pcSel_t pcSel,
	input wire logic [`DATA_WIDTH-1:0] imm,
	input wire logic [`DATA_WIDTH-1:0] target,
	input wire logic halt,
	output logic [`DATA_WIDTH-1:0] pc,
	output logic active,
	output logic halted
);

	typedef enum logic [1:0] {IDLE, RUNNING, STOPPED} runState_t;

	runState_t state;
	logic [`DATA_WIDTH-1:0] nextPc;

	always_comb begin
		case (pcSel)
			PC_REL:  nextPc = pc + imm;
			PC_REG:  nextPc = target;
			PC_HOLD: nextPc = pc;
			default: nextPc = pc + 1'b1;
		endcase
	end

	// Idle lasts one cycle after reset so loading and execution never overlap
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
			state <= IDLE;
		end
		else begin
			pc <= nextPc;
			case (state)
				IDLE: state <= RUNNING;
				RUNNING: if (halt) state <= STOPPED;
				default: state <= STOPPED;
			endcase
		end
	end

	assign active = (state == RUNNING);
	assign halted = (state == STOPPED);

endmodule

`default_nettype wire

// File: hdl/processor.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module processor
	import isaPkg::*, tracePkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire loadWrite_t load,
	output retire_t trace,
	output logic halted,
	output logic [7:0] led
);

	logic [`DATA_WIDTH-1:0] pc;
	instrFields_t instruction;
	control_t ctrl;
	logic [`DATA_WIDTH-1:0] imm;
	logic active;
	logic halt;

	logic [`DATA_WIDTH-1:0] regOut1;
	logic [`DATA_WIDTH-1:0] regOut2;
	logic [`DATA_WIDTH-1:0] wbData;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic zFlag;

	logic [`DATA_WIDTH-1:0] dAddr;
	logic [`DATA_WIDTH-1:0] dDataOut;

	// Instruction port is addressed straight from the PC
	memory mem (
		.clk(clk), .iAddr(pc), .iData(instruction),
		.dAddr(dAddr), .dWrite(ctrl.memWrite), .dDataIn(regOut2),
		.dDataOut(dDataOut), .load(load)
	);

	registerFile regFile (
		.clk(clk), .rst(rst), .we(ctrl.regWrite), .inReg(ctrl.regDest),
		.dataIn(wbData), .outReg1(ctrl.regSrc1), .outReg2(ctrl.regSrc2),
		.dataOut1(regOut1), .dataOut2(regOut2)
	);

	alu arith (
		.clk(clk), .rst(rst), .in1(regOut1), .in2(regOut2), .sub(ctrl.aluSub),
		.update(ctrl.aluUpdate), .result(aluResult), .zFlag(zFlag)
	);

	decoder decode (
		.instruction(instruction), .active(active), .zFlag(zFlag),
		.ctrl(ctrl), .imm(imm)
	);

	// Hold only comes from HALT while running, so it doubles as the stop request
	assign halt = (ctrl.pcSel == PC_HOLD);

	programCounter pcUnit (
		.clk(clk), .rst(rst), .pcSel(ctrl.pcSel), .imm(imm), .target(regOut1),
		.halt(halt), .pc(pc), .active(active), .halted(halted)
	);

	// Write-back source
	always_comb begin
		case (ctrl.wbSel)
			WB_MEM:  wbData = dDataOut;
			WB_IMM:  wbData = imm;
			default: wbData = aluResult;
		endcase
	end

	assign dAddr = ctrl.dAddrFromReg ? regOut1 : imm;

	// Trace reflects what takes effect at the next edge
	always_comb begin
		trace.strobe = active;
		trace.pc = pc;
		trace.instruction = instruction;
		trace.regWrite = ctrl.regWrite;
		trace.regIndex = ctrl.regDest;
		trace.regData = wbData;
		trace.memWrite = ctrl.memWrite;
		trace.memAddr = dAddr;
		trace.memData = regOut2;
	end

	assign led = pc[7:0];

endmodule

`default_nettype wire

// File: test/isaModel.sv
`default_nettype none

`include "cpu_settings.svh"

package isaModel;

	import isaPkg::*;
	import tracePkg::*;

	// Data region used by loads and stores, kept clear of the program
	localparam int unsigned DataBase = 240;

	logic [`DATA_WIDTH-1:0] image [`MEM_DEPTH];
	logic [`DATA_WIDTH-1:0] memWords [`MEM_DEPTH];
	logic [`DATA_WIDTH-1:0] regValues [`REG_COUNT];
	logic [`DATA_WIDTH-1:0] pcValue;
	logic zeroFlag;
	int unsigned fillPos;

	function automatic logic [1:0] anyReg();
		return 2'($urandom_range(0, 3));
	endfunction

	function automatic void emit(opcode_t op, logic [11:0] low);
		image[fillPos] = {op, low};
		fillPos++;
	endfunction

	// Register-only operation, rd limited by the mask
	function automatic void randomAluOp(logic [1:0] rdMask);
		logic [1:0] rd;
		rd = anyReg() & rdMask;
		case ($urandom_range(0, 2))
			0: emit(OP_LI, {rd, 10'($urandom_range(0, 1023))});
			1: emit(OP_ADD, {rd, anyReg(), anyReg(), 6'b0});
			default: emit(OP_SUB, {rd, anyReg(), anyReg(), 6'b0});
		endcase
	endfunction

	// Forward control flow plus counted loops, so every program reaches HALT
	function automatic void buildProgram();
		int unsigned top;
		int unsigned k;
		for (int a = 0; a < `MEM_DEPTH; a++) begin
			image[a] = 16'(a * 40503) ^ 16'h3c5a;
		end
		fillPos = 0;
		while (fillPos < 60) begin
			case ($urandom_range(0, 6))
				0, 1: randomAluOp(2'b11);
				2: begin
					top = $urandom_range(DataBase, 255);
					emit(OP_LI, {2'd3, 10'(top)});
					emit(OP_ST, {anyReg(), 2'd3, 2'd0, 6'b0});
					emit(OP_LD, {anyReg(), 2'd3, 2'd0, 6'b0});
				end
				3: begin
					emit(OP_STA, {anyReg(), 10'($urandom_range(DataBase, 255))});
					emit(OP_LDA, {anyReg(), 10'($urandom_range(DataBase, 255))});
				end
				4: begin
					k = $urandom_range(1, 3);
					emit($urandom_range(0, 1) ? OP_BZ : OP_BR, 12'(k + 1));
					repeat (k) begin
						randomAluOp(2'b11);
					end
				end
				5: begin
					// Jump over one word through r2
					emit(OP_LI, {2'd2, 10'(fillPos + 3)});
					emit(OP_JR, {2'd0, 2'd2, 8'b0});
					randomAluOp(2'b11);
				end
				default: begin
					// r3 counts down by r2, body writes r0 and r1 only
					emit(OP_LI, {2'd3, 10'($urandom_range(1, 4))});
					emit(OP_LI, {2'd2, 10'd1});
					top = fillPos;
					k = $urandom_range(1, 3);
					repeat (k) begin
						randomAluOp(2'b01);
					end
					emit(OP_SUB, {2'd3, 2'd3, 2'd2, 6'b0});
					emit(OP_BZ, 12'd2);
					emit(OP_BR, 12'(top - fillPos));
				end
			endcase
		end
		emit(OP_HALT, 12'd0);
	endfunction

	function automatic void resetModel();
		for (int a = 0; a < `MEM_DEPTH; a++) begin
			memWords[a] = image[a];
		end
		for (int r = 0; r < `REG_COUNT; r++) begin
			regValues[r] = '0;
		end
		pcValue = '0;
		zeroFlag = 1'b0;
	endfunction

	// Executes one instruction and returns what the trace should show
	function automatic retire_t retireNext();
		retire_t t;
		logic [15:0] ins;
		logic [1:0] rd;
		logic [1:0] rs1;
		logic [1:0] rs2;
		logic [15:0] imm;
		logic [15:0] off;
		logic [15:0] result;
		logic [15:0] pcNext;
		ins = memWords[pcValue[7:0]];
		rd = ins[11:10];
		rs1 = ins[9:8];
		rs2 = ins[7:6];
		imm = {{6{ins[9]}}, ins[9:0]};
		off = {{4{ins[11]}}, ins[11:0]};
		t = '0;
		t.strobe = 1'b1;
		t.pc = pcValue;
		t.instruction = ins;
		t.regIndex = rd;
		pcNext = pcValue + 16'd1;
		case (ins[15:12])
			OP_ADD, OP_SUB: begin
				if (ins[15:12] == OP_SUB) begin
					result = regValues[rs1] - regValues[rs2];
				end
				else begin
					result = regValues[rs1] + regValues[rs2];
				end
				zeroFlag = (result == '0);
				t.regWrite = 1'b1;
				t.regData = result;
			end
			OP_LI: begin
				t.regWrite = 1'b1;
				t.regData = imm;
			end
			OP_LD: begin
				t.regWrite = 1'b1;
				t.regData = memWords[regValues[rs1][7:0]];
			end
			OP_LDA: begin
				t.regWrite = 1'b1;
				t.regData = memWords[imm[7:0]];
			end
			OP_ST: begin
				t.memWrite = 1'b1;
				t.memAddr = regValues[rs1];
				t.memData = regValues[rd];
			end
			OP_STA: begin
				t.memWrite = 1'b1;
				t.memAddr = imm;
				t.memData = regValues[rd];
			end
			OP_BZ: pcNext = zeroFlag ? pcValue + off : pcNext;
			OP_BR: pcNext = pcValue + off;
			OP_JR: pcNext = regValues[rs1];
			OP_HALT: pcNext = pcValue;
			default: begin
			end
		endcase
		if (t.regWrite) begin
			regValues[rd] = t.regData;
		end
		if (t.memWrite) begin
			memWords[t.memAddr[7:0]] = t.memData;
		end
		pcValue = pcNext;
		return t;
	endfunction

endpackage

`default_nettype wire

// File: test/tb_processor.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module tb_processor
	import isaPkg::*, tracePkg::*, isaModel::*;
();

	localparam int ProgramCount = 6;
	localparam int RunLimit = 2000;
	localparam int HaltLimit = 8;

	logic clk;
	logic rst;
	loadWrite_t load;
	retire_t trace;
	logic halted;
	logic [7:0] led;

	int mismatches;
	int failures;
	int programsRun;

	processor u_dut (
		.clk(clk),
		.rst(rst),
		.load(load),
		.trace(trace),
		.halted(halted),
		.led(led)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	task automatic reportMismatch(string msg);
		mismatches++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task automatic noteFailure(string msg);
		failures++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	// Four plain reset cycles and then the whole memory image while rst stays high
	task automatic loadImage();
		rst = 1'b1;
		repeat (4) @(negedge clk);
		for (int a = 0; a < `MEM_DEPTH; a++) begin
			load.strobe = 1'b1;
			load.addr = 16'(a);
			load.data = image[a];
			@(negedge clk);
			if (trace.strobe !== 1'b0) begin
				reportMismatch($sformatf("trace strobe high during reset, word %0d", a));
			end
			if (halted !== 1'b0) begin
				reportMismatch($sformatf("halted high during reset, word %0d", a));
			end
		end
		load = '0;
		rst = 1'b0;
	endtask

	task automatic compareTrace(retire_t exp);
		if (trace.pc !== exp.pc || trace.instruction !== exp.instruction) begin
			reportMismatch($sformatf("pc/instr %h/%h, expected %h/%h",
				trace.pc, trace.instruction, exp.pc, exp.instruction));
		end
		if (trace.regWrite !== exp.regWrite) begin
			reportMismatch($sformatf("regWrite %b at pc %h", trace.regWrite, exp.pc));
		end
		else if (exp.regWrite &&
			{trace.regIndex, trace.regData} !== {exp.regIndex, exp.regData}) begin
			reportMismatch($sformatf("r%0d = %h, expected r%0d = %h",
				trace.regIndex, trace.regData, exp.regIndex, exp.regData));
		end
		if (trace.memWrite !== exp.memWrite) begin
			reportMismatch($sformatf("memWrite %b at pc %h", trace.memWrite, exp.pc));
		end
		else if (exp.memWrite &&
			{trace.memAddr, trace.memData} !== {exp.memAddr, exp.memData}) begin
			reportMismatch($sformatf("store %h to %h, expected %h to %h",
				trace.memData, trace.memAddr, exp.memData, exp.memAddr));
		end
		if (led !== exp.pc[7:0]) begin
			reportMismatch($sformatf("led %h at pc %h", led, exp.pc));
		end
		if (halted !== 1'b0) begin
			reportMismatch($sformatf("halted high while retiring pc %h", exp.pc));
		end
	endtask

	task automatic runProgram(int index);
		retire_t expected;
		int cycles;
		logic running;
		logic finished;
		logic [`DATA_WIDTH-1:0] haltPc;
		resetModel();
		running = 1'b0;
		finished = 1'b0;
		haltPc = '0;
		cycles = 0;
		while (!finished && cycles < RunLimit) begin
			@(negedge clk);
			cycles++;
			if (trace.strobe === 1'b1) begin
				if (!running && trace.pc !== '0) begin
					reportMismatch($sformatf("first retire at pc %h, expected 0", trace.pc));
				end
				running = 1'b1;
				expected = retireNext();
				compareTrace(expected);
				if (expected.instruction[15:12] == OP_HALT) begin
					finished = 1'b1;
					haltPc = expected.pc;
				end
			end
			else if (running) begin
				noteFailure($sformatf("program %0d stopped retiring before HALT", index));
				finished = 1'b1;
				haltPc = trace.pc;
			end
		end
		if (!finished) begin
			noteFailure($sformatf("program %0d gave no HALT within %0d cycles", index, RunLimit));
		end
		else begin
			cycles = 0;
			while (halted !== 1'b1 && cycles < HaltLimit) begin
				@(negedge clk);
				cycles++;
			end
			if (halted !== 1'b1) begin
				noteFailure($sformatf("halted never rose in program %0d", index));
			end
			// Core must stay quiet once halted
			repeat (3) begin
				@(negedge clk);
				if (trace.strobe !== 1'b0) begin
					reportMismatch("trace strobe after HALT");
				end
				if (halted !== 1'b1) begin
					reportMismatch("halted dropped after HALT");
				end
			end
			if (led !== haltPc[7:0]) begin
				reportMismatch($sformatf("led %h, expected %h", led, haltPc[7:0]));
			end
			for (int r = 0; r < `REG_COUNT; r++) begin
				if (u_dut.regFile.regs[r] !== regValues[r]) begin
					reportMismatch($sformatf("final r%0d = %h, expected %h",
						r, u_dut.regFile.regs[r], regValues[r]));
				end
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		load = '0;
		mismatches = 0;
		failures = 0;
		programsRun = 0;
		void'($urandom(29140));
		for (int p = 0; p < ProgramCount; p++) begin
			buildProgram();
			loadImage();
			runProgram(p);
			programsRun++;
		end
		$display("Programs: %0d, value mismatches: %0d, other failures: %0d",
			programsRun, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("All tests passed!");
		end
		else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
hdl/isaPkg.sv
hdl/tracePkg.sv
hdl/memory.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/decoder.sv
hdl/programCounter.sv
hdl/processor.sv
test/isaModel.sv
test/tb_processor.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_processor
RTL_TOP    := processor
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS: $(TOP)" || \
		(echo "FAIL: $(TOP), see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
